// File: design/board_pkg.sv
// shared types for the board register bank
// host request, decoded command, read response and pin bundles
// opcode and register enums, status/io word layouts, version constant

package board_pkg;

    // --------------------
    // constants
    localparam logic [31:0] board_version = 32'hC0FFEE;   // hard-wired version number
    localparam logic [3:0]  board_chan    = 4'd0;          // channel of the board registers
    localparam logic [3:0]  first_io_reg  = 4'd7;          // regs 7..15 are not board regs
    localparam int          wdog_w        = 16;            // watchdog period/count width

    // --------------------
    // stream payloads
    typedef struct packed {
        logic        write;   // 1 = write, 0 = read
        logic [7:0]  addr;    // [7:4] channel, [3:0] register
        logic [31:0] wdata;
    } host_req_t;

    typedef enum logic [1:0] {
        op_write,             // write a board register
        op_read,              // read a board register
        op_read_io            // read the io status word
    } cmd_op_e;

    // values 0..6 match the register number on channel 0
    typedef enum logic [2:0] {
        reg_status, reg_phyctrl, reg_phydata, reg_timeout,
        reg_version, reg_tempsns, reg_digiout,
        reg_none              // off-board write, kicks only
    } reg_sel_e;

    typedef struct packed {
        cmd_op_e     op;
        reg_sel_e    reg_sel;
        logic [31:0] wdata;
    } cmd_t;

    typedef struct packed {
        logic [31:0] rdata;
    } rsp_t;

    // --------------------
    // board pins
    typedef struct packed {
        logic [3:0]  neg_limit, pos_limit, home, fault;
        logic        relay, mv_good, v_fault;
        logic [3:0]  board_id;
        logic [15:0] temp_sense;
    } board_in_t;

    typedef struct packed {
        logic [3:0] amp_disable;
        logic [3:0] dout;
        logic       pwr_enable;
        logic       relay_on;
    } board_out_t;

    // status word, low bits first: [7:0] enable (~disable), [15:8] mask,
    // [19:16] fault, [22:20] zero, [23] wdog timeout, [27:24] board id,
    // [28] relay_on, [29] pwr_enable, [31:30] zero
    typedef struct packed {
        logic [1:0] zero_hi;
        logic       pwr_enable;
        logic       relay_on;
        logic [3:0] board_id;
        logic       wdog_timeout;
        logic [2:0] zero_mid;
        logic [3:0] fault;
        logic [7:0] mask;
        logic [7:0] enable;
    } status_word_t;

    // io status, low bits first: home, pos_limit, neg_limit, v_fault, mv_good, relay
    typedef struct packed {
        logic [16:0] zero_hi;
        logic        relay, mv_good, v_fault;
        logic [3:0]  neg_limit, pos_limit, home;
    } io_status_t;

endpackage

// File: design/host_cmd_port.sv
`timescale 1ns/1ps
// host request port
// splits address into channel/register and decodes to a command
// one output register with valid/ready toward the command fifo

module host_cmd_port import board_pkg::*; (
    input  logic      sysclk,
    input  logic      reset,       // sync, active low
    input  host_req_t req,
    input  logic      req_valid,
    output logic      req_ready,
    output cmd_t      cmd,
    output logic      cmd_valid,
    input  logic      cmd_ready
);

    logic [3:0] req_chan;    // address channel nibble
    logic [3:0] req_reg;     // address register nibble
    logic       board_hit;   // channel 0, real board register
    cmd_t       dec_cmd;
    logic       port_en;     // low during reset and one cycle after
    logic       take;        // request accepted this edge

    // --------------------
    // decode
    assign req_chan  = req.addr[7:4];
    assign req_reg   = req.addr[3:0];
    assign board_hit = (req_chan == board_chan) && (req_reg < first_io_reg);

    always_comb begin
        dec_cmd.wdata = req.wdata;
        if (req.write) begin
            dec_cmd.op = op_write;
            // stray writes land on reg_none, still a watchdog kick
            dec_cmd.reg_sel = board_hit ? reg_sel_e'(req_reg[2:0]) : reg_none;
        end else if (board_hit) begin
            dec_cmd.op      = op_read;
            dec_cmd.reg_sel = reg_sel_e'(req_reg[2:0]);
        end else begin
            dec_cmd.op      = op_read_io;   // regs 7..15 or other channel
            dec_cmd.reg_sel = reg_none;
        end
    end

    // --------------------
    // output register
    assign req_ready = port_en && (!cmd_valid || cmd_ready);   // empty or draining
    assign take      = req_valid && req_ready;

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            port_en   <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            port_en <= 1'b1;
            if (take)
                cmd_valid <= 1'b1;
            else if (cmd_ready)
                cmd_valid <= 1'b0;      // drained, nothing new
        end
    end

    // payload only, valid qualifies it
    always_ff @(posedge sysclk) begin
        if (take)
            cmd <= dec_cmd;
    end

endmodule

// File: design/cmd_fifo.sv
`timescale 1ns/1ps
// command fifo between request port and register bank
// circular buffer, read/write pointers plus occupancy count
// push and pop allowed in the same cycle

module cmd_fifo import board_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic sysclk,
    input  logic reset,         // sync, active low
    input  cmd_t in_cmd,
    input  logic in_valid,
    output logic in_ready,
    output cmd_t out_cmd,
    output logic out_valid,
    input  logic out_ready
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    cmd_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;     // entries held
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(FIFO_DEPTH));   // low when full
    assign out_valid = (count != '0);
    assign out_cmd   = mem[rd_ptr];                      // head of queue
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // --------------------
    // pointers and count
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    // storage, no reset
    always_ff @(posedge sysclk) begin
        if (push)
            mem[wr_ptr] <= in_cmd;
    end

endmodule

// File: design/wdog_timer.sv
`timescale 1ns/1ps
// watchdog timer
// free-running prescaler tick, period counter, timeout flag
// any register write clears count and flag

module wdog_timer import board_pkg::*; #(
    parameter int WDOG_SHIFT = 8
) (
    input  logic              sysclk,
    input  logic              reset,     // sync, active low
    input  logic              kick,      // one pulse per popped write
    input  logic [wdog_w-1:0] period,    // in ticks, 0 = off
    output logic              timeout
);

    logic [WDOG_SHIFT-1:0] prescale;     // wraps every 2^WDOG_SHIFT cycles
    logic                  tick;
    logic [wdog_w-1:0]     count;        // ticks since last kick

    assign tick = &prescale;

    // --------------------
    // prescaler
    always_ff @(posedge sysclk) begin
        if (!reset)
            prescale <= '0;
        else
            prescale <= prescale + 1'b1;
    end

    // --------------------
    // counter and flag
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            count   <= '0;
            timeout <= 1'b0;
        end else if (kick) begin
            count   <= '0;               // host still alive
            timeout <= 1'b0;
        end else if (tick && (period != '0)) begin
            if (count < period)
                count <= count + 1'b1;
            else
                timeout <= 1'b1;         // period reached, latch until kick
        end
    end

endmodule

// File: design/board_regs.sv
`timescale 1ns/1ps
// board register bank
// masked amp enable writes, phy/timeout/dout registers
// read mux into a response register, pin outputs, watchdog kick

module board_regs import board_pkg::*; (
    input  logic              sysclk,
    input  logic              reset,          // sync, active low
    input  cmd_t              cmd,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    output rsp_t              rsp,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    input  board_in_t         pins_in,
    output board_out_t        pins_out,
    output logic              wdog_kick,
    output logic [wdog_w-1:0] wdog_period,
    input  logic              wdog_timeout
);

    // registered state
    logic [15:0]       reg_disable;     // [7:0] disables, [15:8] last mask
    logic [15:0]       phy_ctrl;        // phy request bitstream
    logic [15:0]       phy_data;        // phy register contents
    logic [wdog_w-1:0] wdog_period_q;   // 0 = watchdog off
    logic [3:0]        dout_q;
    logic              relay_on_q;

    // combinational
    logic              is_read;
    logic              pop;
    logic              do_write;
    logic [7:0]        dis_lo_next;     // masked disable update
    status_word_t      status_w;
    io_status_t        io_w;
    logic [31:0]       rd_data;

    // --------------------
    // handshake
    assign is_read   = (cmd.op != op_write);
    // reads wait for a free (or draining) response slot
    assign cmd_ready = !is_read || !rsp_valid || rsp_ready;
    assign pop       = cmd_valid && cmd_ready;
    assign do_write  = pop && !is_read;
    assign wdog_kick = do_write;        // kicks on every popped write including reg_none

    // set disable bit i to ~wdata[i] where mask bit 8+i is set
    assign dis_lo_next = (reg_disable[7:0] & ~cmd.wdata[15:8])
                       | (~cmd.wdata[7:0] & cmd.wdata[15:8]);

    // --------------------
    // register writes
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            reg_disable   <= 16'h00FF;   // all amps off
            phy_ctrl      <= '0;
            phy_data      <= '0;
            wdog_period_q <= '0;
            dout_q        <= '0;
            relay_on_q    <= 1'b0;       // safety relay open
        end else if (do_write) begin
            unique case (cmd.reg_sel)
                reg_status: begin
                    reg_disable <= {cmd.wdata[15:8], dis_lo_next};
                    relay_on_q  <= cmd.wdata[16];
                end
                reg_phyctrl: phy_ctrl      <= cmd.wdata[15:0];
                reg_phydata: phy_data      <= cmd.wdata[15:0];
                reg_timeout: wdog_period_q <= cmd.wdata[wdog_w-1:0];
                reg_digiout: dout_q        <= cmd.wdata[3:0];
                default:     ;            // version, tempsns and none only kick
            endcase
        end
    end

    // --------------------
    // read mux
    always_comb begin
        status_w              = '0;
        status_w.enable       = ~reg_disable[7:0];
        status_w.mask         = reg_disable[15:8];
        status_w.fault        = pins_in.fault;
        status_w.wdog_timeout = wdog_timeout;
        status_w.board_id     = pins_in.board_id;
        status_w.relay_on     = relay_on_q;
        status_w.pwr_enable   = 1'b1;        // supply always on

        io_w           = '0;
        io_w.relay     = pins_in.relay;
        io_w.mv_good   = pins_in.mv_good;
        io_w.v_fault   = pins_in.v_fault;
        io_w.neg_limit = pins_in.neg_limit;
        io_w.pos_limit = pins_in.pos_limit;
        io_w.home      = pins_in.home;

        if (cmd.op == op_read_io) begin
            rd_data = io_w;
        end else begin
            unique case (cmd.reg_sel)
                reg_status:  rd_data = status_w;
                reg_phyctrl: rd_data = {16'd0, phy_ctrl};
                reg_phydata: rd_data = {16'd0, phy_data};
                reg_timeout: rd_data = 32'(wdog_period_q);
                reg_version: rd_data = board_version;
                reg_tempsns: rd_data = {16'd0, pins_in.temp_sense};
                reg_digiout: rd_data = {28'd0, dout_q};
                default:     rd_data = io_w;        // reg_none
            endcase
        end
    end

    // --------------------
    // response register
    always_ff @(posedge sysclk) begin
        if (!reset)
            rsp_valid <= 1'b0;
        else if (pop && is_read)
            rsp_valid <= 1'b1;
        else if (rsp_ready)
            rsp_valid <= 1'b0;
    end

    always_ff @(posedge sysclk) begin
        if (pop && is_read)
            rsp.rdata <= rd_data;   // held until taken
    end

    // --------------------
    // pins
    assign pins_out.amp_disable = wdog_timeout ? 4'hF : reg_disable[3:0];  // timeout forces off
    assign pins_out.dout        = dout_q;
    assign pins_out.pwr_enable  = 1'b1;
    assign pins_out.relay_on    = relay_on_q;
    assign wdog_period          = wdog_period_q;

endmodule

// File: design/board_ctrl_top.sv
`timescale 1ns/1ps
// top level of the board register subsystem
// request port -> command fifo -> register bank, plus watchdog

module board_ctrl_top import board_pkg::*; #(
    parameter int FIFO_DEPTH = 4,
    parameter int WDOG_SHIFT = 8
) (
    input  logic       sysclk,
    input  logic       reset,        // sync, active low
    input  host_req_t  req,
    input  logic       req_valid,
    output logic       req_ready,
    output rsp_t       rsp,
    output logic       rsp_valid,
    input  logic       rsp_ready,
    input  board_in_t  pins_in,
    output board_out_t pins_out
);

    // --------------------
    // internal streams
    cmd_t              port_cmd;     // port -> fifo
    logic              port_valid;
    logic              port_ready;
    cmd_t              fifo_cmd;     // fifo -> regs
    logic              fifo_valid;
    logic              fifo_ready;
    logic              wdog_kick;
    logic [wdog_w-1:0] wdog_period;
    logic              wdog_timeout;

    host_cmd_port host_cmd_port_i (
        .sysclk(sysclk), .reset(reset),
        .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .cmd(port_cmd), .cmd_valid(port_valid), .cmd_ready(port_ready)
    );

    cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) cmd_fifo_i (
        .sysclk(sysclk), .reset(reset),
        .in_cmd(port_cmd), .in_valid(port_valid), .in_ready(port_ready),
        .out_cmd(fifo_cmd), .out_valid(fifo_valid), .out_ready(fifo_ready)
    );

    board_regs board_regs_i (
        .sysclk(sysclk), .reset(reset),
        .cmd(fifo_cmd), .cmd_valid(fifo_valid), .cmd_ready(fifo_ready),
        .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
        .pins_in(pins_in), .pins_out(pins_out),
        .wdog_kick(wdog_kick), .wdog_period(wdog_period), .wdog_timeout(wdog_timeout)
    );

    wdog_timer #(.WDOG_SHIFT(WDOG_SHIFT)) wdog_timer_i (
        .sysclk(sysclk), .reset(reset),
        .kick(wdog_kick), .period(wdog_period), .timeout(wdog_timeout)
    );

endmodule

// File: verif/board_ctrl_chk.sv
`timescale 1ns/1ps
// assertions bound into the register bank
// response hold under back-pressure, watchdog forces amps off,
// no response right out of reset

module board_ctrl_chk import board_pkg::*; (
    input logic       sysclk,
    input logic       reset,         // sync, active low
    input rsp_t       rsp,
    input logic       rsp_valid,
    input logic       rsp_ready,
    input board_out_t pins_out,
    input logic       wdog_timeout
);

    // --------------------
    // response stream
    // stalled response keeps valid and data
    rsp_hold_a: assert property (@(posedge sysclk) disable iff (!reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("response changed while stalled");

    // nothing pending the cycle after reset
    rsp_reset_a: assert property (@(posedge sysclk)
        !reset |=> !rsp_valid)
        else $error("response valid right after reset");

    // --------------------
    // safety
    amp_off_a: assert property (@(posedge sysclk) disable iff (!reset)
        wdog_timeout |-> pins_out.amp_disable == 4'hF)
        else $error("amplifier enabled during watchdog timeout");

endmodule

bind board_regs board_ctrl_chk board_ctrl_chk_i (
    .sysclk(sysclk), .reset(reset),
    .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
    .pins_out(pins_out), .wdog_timeout(wdog_timeout)
);

// File: verif/board_ctrl_tb.sv
`timescale 1ns/1ps
// testbench for the board register subsystem
// reference model, stimulus table, compare tasks
// back-pressure and watchdog tests

module board_ctrl_tb import board_pkg::*; ();

    typedef struct packed {
        logic        write;
        logic [7:0]  addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;    // reads only
        board_out_t  exp_pins;     // pins once the entry is done
    } step_t;

    localparam int FIFO_DEPTH = 4;
    localparam int WDOG_SHIFT = 2;     // tick every 4 cycles
    localparam int MAX_WAIT   = 60;    // cycles per wait loop

    logic       sysclk;
    logic       reset;
    host_req_t  req;
    logic       req_valid;
    logic       req_ready;
    rsp_t       rsp;
    logic       rsp_valid;
    logic       rsp_ready;
    board_in_t  pins_in;
    board_out_t pins_out;

    int    seed = 68642;
    step_t table_q[$];
    rsp_t  exp_q[$];          // back-pressure reads, in issue order

    // reference model state
    logic [15:0] m_dis;       // [7:0] disables, [15:8] mask
    logic        m_relay;
    logic [3:0]  m_dout;
    logic [15:0] m_phyctrl;
    logic [15:0] m_phydata;
    logic [15:0] m_period;

    board_ctrl_top #(.FIFO_DEPTH(FIFO_DEPTH), .WDOG_SHIFT(WDOG_SHIFT)) board_ctrl_top_i (
        .sysclk(sysclk), .reset(reset),
        .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
        .pins_in(pins_in), .pins_out(pins_out)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;    // 20 ns
    end

    // --------------------
    // reporting
    task automatic stop_sim();
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rsp(input rsp_t got, input rsp_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR rsp.rdata (%s): got %h expected %h", what, got.rdata, exp.rdata);
            stop_sim();
        end
    endtask

    task automatic check_pins(input board_out_t got, input board_out_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR pins_out (%s): got %h expected %h", what, got, exp);
            stop_sim();
        end
    endtask

    // --------------------
    // reference model
    function automatic logic is_board_reg(input logic [7:0] addr);
        return (addr[7:4] == 4'd0) && (addr[3:0] <= 4'd6);
    endfunction

    task automatic model_write(input logic [7:0] addr, input logic [31:0] d);
        if (is_board_reg(addr)) begin
            case (addr[3:0])
                4'd0: begin
                    for (int i = 0; i < 8; i++)
                        if (d[8+i])
                            m_dis[i] = !d[i];    // masked enable bit
                    m_dis[15:8] = d[15:8];
                    m_relay     = d[16];
                end
                4'd1:    m_phyctrl = d[15:0];
                4'd2:    m_phydata = d[15:0];
                4'd3:    m_period  = d[15:0];
                4'd6:    m_dout    = d[3:0];
                default: ;                       // version, tempsns
            endcase
        end
    endtask

    function automatic logic [31:0] model_read(input logic [7:0] addr, input logic wdog);
        logic [31:0] io_word;
        io_word = {17'd0, pins_in.relay, pins_in.mv_good, pins_in.v_fault,
                   pins_in.neg_limit, pins_in.pos_limit, pins_in.home};
        if (!is_board_reg(addr))
            return io_word;
        case (addr[3:0])
            4'd0: return {2'b00, 1'b1, m_relay, pins_in.board_id, wdog, 3'b000,
                          pins_in.fault, m_dis[15:8], ~m_dis[7:0]};
            4'd1:    return {16'd0, m_phyctrl};
            4'd2:    return {16'd0, m_phydata};
            4'd3:    return {16'd0, m_period};
            4'd4:    return 32'h00C0FFEE;
            4'd5:    return {16'd0, pins_in.temp_sense};
            default: return {28'd0, m_dout};
        endcase
    endfunction

    function automatic board_out_t model_pins(input logic wdog);
        board_out_t p;
        p.amp_disable = wdog ? 4'hF : m_dis[3:0];
        p.dout        = m_dout;
        p.pwr_enable  = 1'b1;
        p.relay_on    = m_relay;
        return p;
    endfunction

    task automatic add_step(input logic wr, input logic [7:0] addr, input logic [31:0] d);
        step_t s;
        if (wr)
            model_write(addr, d);
        s.write     = wr;
        s.addr      = addr;
        s.wdata     = d;
        s.exp_rdata = wr ? 32'd0 : model_read(addr, 1'b0);
        s.exp_pins  = model_pins(1'b0);
        table_q.push_back(s);
    endtask

    task automatic build_table();
        logic [31:0] d;
        add_step(1'b0, 8'h04, 32'd0);                  // reset values
        add_step(1'b0, 8'h03, 32'd0);
        add_step(1'b0, 8'h00, 32'd0);
        add_step(1'b0, 8'h06, 32'd0);
        for (int r = 1; r <= 2; r++) begin             // phy registers
            d = $random(seed);
            add_step(1'b1, {4'd0, 4'(r)}, d);
            add_step(1'b0, {4'd0, 4'(r)}, 32'd0);
        end
        d = $random(seed) | 32'h0000_8000;             // long period, no timeout here
        add_step(1'b1, 8'h03, d);
        add_step(1'b0, 8'h03, 32'd0);
        add_step(1'b1, 8'h03, 32'd0);                  // watchdog off again
        add_step(1'b0, 8'h03, 32'd0);
        d = $random(seed);
        add_step(1'b1, 8'h06, d);                      // dout shows on pins
        add_step(1'b0, 8'h06, 32'd0);
        add_step(1'b1, 8'h04, $random(seed));          // version is read only
        add_step(1'b1, 8'h36, $random(seed));          // other channel
        add_step(1'b1, 8'h0B, $random(seed));          // reg 11, no board reg
        add_step(1'b0, 8'h04, 32'd0);
        add_step(1'b0, 8'h06, 32'd0);
        add_step(1'b0, 8'h01, 32'd0);
        for (int k = 0; k < 8; k++) begin              // masked enables
            d = $random(seed);
            add_step(1'b1, 8'h00, d);
            add_step(1'b0, 8'h00, 32'd0);
        end
        add_step(1'b0, 8'h07, 32'd0);                  // io status word
        add_step(1'b0, 8'h0F, 32'd0);
        add_step(1'b0, 8'h25, 32'd0);
        add_step(1'b0, 8'h05, 32'd0);                  // temperature
    endtask

    // --------------------
    // handshakes, entered and left on a falling edge
    task automatic send_req(input logic wr, input logic [7:0] addr, input logic [31:0] d);
        int n;
        req       = {wr, addr, d};
        req_valid = 1'b1;
        n         = 0;
        while (!req_ready) begin
            @(negedge sysclk);
            n++;
            if (n > MAX_WAIT) begin
                $display("request to address %h was never accepted", addr);
                stop_sim();
            end
        end
        @(negedge sysclk);          // taken on the rising edge in between
        req_valid = 1'b0;
    endtask

    task automatic get_rsp(output rsp_t got);
        int n;
        n = 0;
        while (!rsp_valid) begin
            @(negedge sysclk);
            n++;
            if (n > MAX_WAIT) begin
                $display("no read response arrived in time");
                stop_sim();
            end
        end
        got = rsp;
        @(negedge sysclk);          // rsp_ready high, taken
    endtask

    task automatic wait_pins(input board_out_t exp, input string what);
        int n;
        n = 0;
        while (pins_out !== exp && n < MAX_WAIT) begin
            @(negedge sysclk);
            n++;
        end
        check_pins(pins_out, exp, what);
    endtask

    // --------------------
    // main sequence
    initial begin
        rsp_t        got;
        int          n;
        logic [63:0] rnd;
        board_out_t  rst_pins;

        reset     = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b1;
        rnd       = {$random(seed), $random(seed)};
        pins_in   = rnd[38:0];
        m_dis     = 16'h00FF;    // model reset state
        m_relay   = 1'b0;
        m_dout    = 4'd0;
        m_phyctrl = 16'd0;
        m_phydata = 16'd0;
        m_period  = 16'd0;
        rst_pins  = '{amp_disable: 4'hF, dout: 4'h0, pwr_enable: 1'b1, relay_on: 1'b0};

        repeat (5) @(negedge sysclk);
        if (req_ready !== 1'b0 || rsp_valid !== 1'b0) begin
            $display("handshake outputs not low during reset");
            stop_sim();
        end
        check_pins(pins_out, rst_pins, "reset");
        reset = 1'b1;

        // table of writes and reads
        build_table();
        foreach (table_q[i]) begin
            send_req(table_q[i].write, table_q[i].addr, table_q[i].wdata);
            if (!table_q[i].write) begin
                get_rsp(got);
                check_rsp(got, rsp_t'(table_q[i].exp_rdata),
                          $sformatf("table read of %h", table_q[i].addr));
            end
            wait_pins(table_q[i].exp_pins, $sformatf("table entry %0d", i));
        end

        // back-pressure: stall responses until the request port fills
        rsp_ready = 1'b0;
        n = 0;
        while (req_ready && n < 12) begin
            send_req(1'b0, {4'd0, 4'(n)}, 32'd0);
            exp_q.push_back(rsp_t'(model_read({4'd0, 4'(n)}, 1'b0)));
            n++;
        end
        if (req_ready || n <= FIFO_DEPTH) begin
            $display("req_ready did not fall under back-pressure, %0d reads taken", n);
            stop_sim();
        end
        rsp_ready = 1'b1;
        while (exp_q.size() > 0) begin
            get_rsp(got);
            check_rsp(got, exp_q.pop_front(), "back-pressure read");
        end

        // watchdog: amps 1 and 3 enabled, period 3, then silence
        send_req(1'b1, 8'h00, 32'h0000_0F0A);
        model_write(8'h00, 32'h0000_0F0A);
        wait_pins(model_pins(1'b0), "enables before watchdog");
        send_req(1'b1, 8'h03, 32'd3);
        model_write(8'h03, 32'd3);
        n = 0;
        while (pins_out.amp_disable !== 4'hF && n < (3 + 2) * 4 + 10) begin
            @(negedge sysclk);
            n++;
        end
        check_pins(pins_out, model_pins(1'b1), "watchdog timeout");
        if (n < 3 * 4) begin
            $display("watchdog timed out too early, after %0d cycles", n);
            stop_sim();
        end
        send_req(1'b0, 8'h00, 32'd0);
        get_rsp(got);
        check_rsp(got, rsp_t'(model_read(8'h00, 1'b1)), "status during timeout");

        // next write clears the flag, period 0 stops the watchdog
        send_req(1'b1, 8'h03, 32'd0);
        model_write(8'h03, 32'd0);
        wait_pins(model_pins(1'b0), "pins after kick");
        send_req(1'b0, 8'h00, 32'd0);
        get_rsp(got);
        check_rsp(got, rsp_t'(model_read(8'h00, 1'b0)), "status after kick");

        $display("Everything OK");
        $finish;
    end

endmodule

// File: build.f
design/board_pkg.sv
design/host_cmd_port.sv
design/cmd_fifo.sv
design/wdog_timer.sv
design/board_regs.sv
design/board_ctrl_top.sv
verif/board_ctrl_chk.sv
verif/board_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the board register testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 --assert --top-module board_ctrl_tb -f build.f -o board_ctrl_sim

./obj_dir/board_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "RESULT: FAIL"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "RESULT: FAIL, simulation ended early"
    exit 1
fi
echo "RESULT: PASS"
